//--- Makefile
VERILATOR ?= verilator
TOP       ?= spriteEngineTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- design/pixelCompositor.sv
`timescale 1ns/100ps

module pixelCompositor (
    input  logic                  Clk,
    input  logic                  arstN,
    input  spritePkg::spriteWordT readData,
    input  logic                  hit,
    input  logic                  byteSel,
    input  logic                  active,
    input  logic                  hSync,
    input  logic                  vSync,
    input  spritePkg::colourT     backgroundColour,
    output spritePkg::colourT     colour,
    output logic                  outHSync,
    output logic                  outVSync,
    output logic                  activeVideo
);

    logic                  hitD;
    logic                  byteSelD;
    logic                  activeD;
    logic                  hSyncD;
    logic                  vSyncD;
    spritePkg::pixelIndexT pixelIndex;
    spritePkg::colourT     spriteColour;
    spritePkg::colourT     nextColour;

    // one stage of delay so the flags line up with the registered memory read
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            hitD    <= 1'b0;
            activeD <= 1'b0;
            hSyncD  <= 1'b1;
            vSyncD  <= 1'b1;
        end else begin
            hitD    <= hit;
            activeD <= active;
            hSyncD  <= hSync;
            vSyncD  <= vSync;
        end
    end

    always_ff @(posedge Clk) begin
        byteSelD <= byteSel;
    end

    assign pixelIndex = byteSelD ? readData[15:8] : readData[7:0];

    // RGB332 to 4:4:4, the top bits are repeated to fill the low end
    assign spriteColour = {pixelIndex[7:5], pixelIndex[7],
                           pixelIndex[4:2], pixelIndex[4],
                           pixelIndex[1:0], pixelIndex[1:0]};

    always_comb begin
        if (!activeD) begin
            nextColour = '0;
        end else if (hitD && (pixelIndex != '0)) begin
            nextColour = spriteColour;
        end else begin
            // transparent index or no sprite here
            nextColour = backgroundColour;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            colour      <= '0;
            outHSync    <= 1'b1;
            outVSync    <= 1'b1;
            activeVideo <= 1'b0;
        end else begin
            colour      <= nextColour;
            outHSync    <= hSyncD;
            outVSync    <= vSyncD;
            activeVideo <= activeD;
        end
    end

    blankIsBlack: assert property (@(posedge Clk) disable iff (!arstN)
        !activeVideo |-> (colour == '0));

endmodule

//--- design/scanTimer.sv
`timescale 1ns/100ps

module scanTimer #(
    parameter int activeWidth  = 160,
    parameter int activeHeight = 120,
    parameter int totalWidth   = 200,
    parameter int totalHeight  = 130
) (
    input  logic            Clk,
    input  logic            arstN,
    output spritePkg::coordT scanX,
    output spritePkg::coordT scanY,
    output logic            scanActive,
    output logic            scanHSync,
    output logic            scanVSync
);

    spritePkg::coordT hCount;
    spritePkg::coordT vCount;
    logic             hSyncZone;
    logic             vSyncZone;

    // free-running raster position, one pixel per clock
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            hCount <= '0;
            vCount <= '0;
        end else begin
            if (hCount == spritePkg::coordT'(totalWidth - 1)) begin
                hCount <= '0;
                if (vCount == spritePkg::coordT'(totalHeight - 1)) begin
                    vCount <= '0;
                end else begin
                    vCount <= vCount + 1'b1;
                end
            end else begin
                hCount <= hCount + 1'b1;
            end
        end
    end

    // sync pulses sit a little way into the blanking on each axis
    assign hSyncZone = (hCount >= spritePkg::coordT'(activeWidth + 8)) &&
                       (hCount <= spritePkg::coordT'(activeWidth + 23));
    assign vSyncZone = (vCount == spritePkg::coordT'(activeHeight + 2)) ||
                       (vCount == spritePkg::coordT'(activeHeight + 3));

    // position, active level and syncs all leave through one register so they stay aligned
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            scanX      <= '0;
            scanY      <= '0;
            scanActive <= 1'b0;
            scanHSync  <= 1'b1;
            scanVSync  <= 1'b1;
        end else begin
            scanX      <= hCount;
            scanY      <= vCount;
            scanActive <= (hCount < spritePkg::coordT'(activeWidth)) &&
                          (vCount < spritePkg::coordT'(activeHeight));
            scanHSync  <= !hSyncZone;
            scanVSync  <= !vSyncZone;
        end
    end

    xInRange: assert property (@(posedge Clk) disable iff (!arstN)
        scanX < spritePkg::coordT'(totalWidth));

endmodule

//--- design/spriteEngine.sv
`timescale 1ns/100ps

module spriteEngine #(
    parameter int activeWidth  = 160,
    parameter int activeHeight = 120,
    parameter int totalWidth   = 200,
    parameter int totalHeight  = 130
) (
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic                  writeEnable,
    input  spritePkg::spriteAddrT writeAddr,
    input  spritePkg::spriteWordT writeData,
    input  spritePkg::coordT      p0X,
    input  spritePkg::coordT      p0Y,
    input  spritePkg::coordT      p1X,
    input  spritePkg::coordT      p1Y,
    input  spritePkg::headingT    p0Heading,
    input  spritePkg::headingT    p1Heading,
    input  spritePkg::colourT     backgroundColour,
    output spritePkg::colourT     colour,
    output logic                  hSync,
    output logic                  vSync,
    output logic                  activeVideo
);

    spritePkg::coordT      scanX;
    spritePkg::coordT      scanY;
    logic                  scanActive;
    logic                  scanHSync;
    logic                  scanVSync;
    spritePkg::spriteAddrT readAddr;
    spritePkg::spriteWordT readData;
    logic                  hit;
    logic                  byteSel;
    logic                  locActive;
    logic                  locHSync;
    logic                  locVSync;

    scanTimer #(
        .activeWidth (activeWidth),
        .activeHeight(activeHeight),
        .totalWidth  (totalWidth),
        .totalHeight (totalHeight)
    ) scanTimer_i (
        .Clk       (Clk),
        .arstN     (arstN),
        .scanX     (scanX),
        .scanY     (scanY),
        .scanActive(scanActive),
        .scanHSync (scanHSync),
        .scanVSync (scanVSync)
    );

    spriteLocator #(
        .activeWidth (activeWidth),
        .activeHeight(activeHeight)
    ) spriteLocator_i (
        .Clk       (Clk),
        .arstN     (arstN),
        .scanX     (scanX),
        .scanY     (scanY),
        .scanActive(scanActive),
        .scanHSync (scanHSync),
        .scanVSync (scanVSync),
        .p0X       (p0X),
        .p0Y       (p0Y),
        .p1X       (p1X),
        .p1Y       (p1Y),
        .p0Heading (p0Heading),
        .p1Heading (p1Heading),
        .readAddr  (readAddr),
        .hit       (hit),
        .byteSel   (byteSel),
        .active    (locActive),
        .hSync     (locHSync),
        .vSync     (locVSync)
    );

    spriteRam spriteRam_i (
        .Clk        (Clk),
        .writeEnable(writeEnable),
        .writeAddr  (writeAddr),
        .writeData  (writeData),
        .readAddr   (readAddr),
        .readData   (readData)
    );

    pixelCompositor pixelCompositor_i (
        .Clk             (Clk),
        .arstN           (arstN),
        .readData        (readData),
        .hit             (hit),
        .byteSel         (byteSel),
        .active          (locActive),
        .hSync           (locHSync),
        .vSync           (locVSync),
        .backgroundColour(backgroundColour),
        .colour          (colour),
        .outHSync        (hSync),
        .outVSync        (vSync),
        .activeVideo     (activeVideo)
    );

endmodule

//--- design/spriteLocator.sv
`timescale 1ns/100ps

module spriteLocator #(
    parameter int activeWidth  = 160,
    parameter int activeHeight = 120
) (
    input  logic                 Clk,
    input  logic                 arstN,
    input  spritePkg::coordT     scanX,
    input  spritePkg::coordT     scanY,
    input  logic                 scanActive,
    input  logic                 scanHSync,
    input  logic                 scanVSync,
    input  spritePkg::coordT     p0X,
    input  spritePkg::coordT     p0Y,
    input  spritePkg::coordT     p1X,
    input  spritePkg::coordT     p1Y,
    input  spritePkg::headingT   p0Heading,
    input  spritePkg::headingT   p1Heading,
    output spritePkg::spriteAddrT readAddr,
    output logic                 hit,
    output logic                 byteSel,
    output logic                 active,
    output logic                 hSync,
    output logic                 vSync
);

    spritePkg::coordT   p0DX;
    spritePkg::coordT   p0DY;
    spritePkg::coordT   p1DX;
    spritePkg::coordT   p1DY;
    logic               in0;
    logic               in1;
    spritePkg::coordT   selDX;
    spritePkg::coordT   selDY;
    spritePkg::headingT selHeading;

    // offsets from each player's top-left corner are only meaningful once the pixel is past it
    assign p0DX = scanX - p0X;
    assign p0DY = scanY - p0Y;
    assign p1DX = scanX - p1X;
    assign p1DY = scanY - p1Y;

    assign in0 = (scanX >= p0X) && (scanY >= p0Y) &&
                 (p0DX < spritePkg::coordT'(spritePkg::spriteSize)) &&
                 (p0DY < spritePkg::coordT'(spritePkg::spriteSize));
    assign in1 = (scanX >= p1X) && (scanY >= p1Y) &&
                 (p1DX < spritePkg::coordT'(spritePkg::spriteSize)) &&
                 (p1DY < spritePkg::coordT'(spritePkg::spriteSize));

    // player 0 wins wherever both boxes cover the pixel
    assign selDX      = in0 ? p0DX : p1DX;
    assign selDY      = in0 ? p0DY : p1DY;
    assign selHeading = in0 ? p0Heading : p1Heading;

    // word address and byte select of the pixel within the chosen sprite
    always_ff @(posedge Clk) begin
        readAddr <= {!in0, selHeading, selDY[4:0], selDX[4:1]};
        byteSel  <= selDX[0];
    end

    // gating with the active level clips sprites hanging over the right or bottom edge
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            hit    <= 1'b0;
            active <= 1'b0;
            hSync  <= 1'b1;
            vSync  <= 1'b1;
        end else begin
            hit    <= scanActive && (in0 || in1);
            active <= scanActive;
            hSync  <= scanHSync;
            vSync  <= scanVSync;
        end
    end

    hitOnlyWhenActive: assert property (@(posedge Clk) disable iff (!arstN)
        hit |-> active);

    // the timer's active level must agree with the raster size this stage was built for
    activeInsideArea: assert property (@(posedge Clk) disable iff (!arstN)
        scanActive |-> (scanX < spritePkg::coordT'(activeWidth)) &&
                       (scanY < spritePkg::coordT'(activeHeight)));

endmodule

//--- design/spritePkg.sv
package spritePkg;

    // screen coordinate, wide enough for the full raster including blanking
    typedef logic [9:0] coordT;

    // sprite memory word address, packed from the top as
    // player (1), heading (2), row (5) and column pair (4)
    typedef logic [11:0] spriteAddrT;

    // two pixels per word, even column in the low byte and odd column in the high byte
    typedef logic [15:0] spriteWordT;

    // RGB332 pixel index, zero is transparent
    typedef logic [7:0] pixelIndexT;

    // output colour, 4 bits each of red, green and blue
    typedef logic [11:0] colourT;

    // bike direction, also selects one of the four images per player
    typedef enum logic [1:0] {
        up    = 2'd0,
        down  = 2'd1,
        left  = 2'd2,
        right = 2'd3
    } headingT;

    // sprite edge in pixels
    localparam int spriteSize = 32;

endpackage

//--- design/spriteRam.sv
`timescale 1ns/100ps

module spriteRam (
    input  logic                  Clk,
    input  logic                  writeEnable,
    input  spritePkg::spriteAddrT writeAddr,
    input  spritePkg::spriteWordT writeData,
    input  spritePkg::spriteAddrT readAddr,
    output spritePkg::spriteWordT readData
);

    localparam int depth = 2 ** $bits(spritePkg::spriteAddrT);

    // eight 32 by 32 bike images, two pixels per word
    spritePkg::spriteWordT mem [0:depth-1];

    // a read of the address being written returns the old word
    always_ff @(posedge Clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= writeData;
        end
        readData <= mem[readAddr];
    end

    knownWriteData: assert property (@(posedge Clk)
        writeEnable |-> !$isunknown(writeData));

endmodule

//--- filelist.f
design/spritePkg.sv
design/scanTimer.sv
design/spriteLocator.sv
design/spriteRam.sv
design/pixelCompositor.sv
design/spriteEngine.sv
test/clockGen.sv
test/spriteChecker.sv
test/spriteEngineTb.sv

//--- test/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
    parameter int period      = 4,
    parameter int resetCycles = 5
) (
    output logic Clk,
    output logic arstN
);

    initial begin
        Clk = 1'b0;
        forever #(period / 2) Clk = !Clk;
    end

    // release lands just after a rising edge, well clear of the next one
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge Clk);
        #1;
        arstN = 1'b1;
    end

endmodule

//--- test/spriteChecker.sv
`timescale 1ns/100ps

module spriteChecker #(
    parameter int activeWidth  = 160,
    parameter int activeHeight = 120,
    parameter int totalWidth   = 200,
    parameter int totalHeight  = 130
) (
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic                  writeEnable,
    input  spritePkg::spriteAddrT writeAddr,
    input  spritePkg::spriteWordT writeData,
    input  spritePkg::coordT      p0X,
    input  spritePkg::coordT      p0Y,
    input  spritePkg::coordT      p1X,
    input  spritePkg::coordT      p1Y,
    input  spritePkg::headingT    p0Heading,
    input  spritePkg::headingT    p1Heading,
    input  spritePkg::colourT     backgroundColour,
    input  spritePkg::colourT     colour,
    input  logic                  hSync,
    input  logic                  vSync,
    input  logic                  activeVideo,
    output int                    checkCount,
    output int                    errorCount,
    output int                    spriteCount
);

    // cycles from a raster position to its output pixel
    localparam int latency    = 3;
    localparam int maxReports = 8;

    spritePkg::spriteWordT shadow [0:4095];
    int                    edgeCount;
    int                    modelX;
    int                    modelY;

    always @(posedge Clk) begin
        if (writeEnable) begin
            shadow[writeAddr] <= writeData;
        end
    end

    // counts edges since reset release until pixel (0,0) leaves on edge latency + 1
    always @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            edgeCount <= 0;
        end else if (edgeCount <= latency) begin
            edgeCount <= edgeCount + 1;
        end
    end

    function automatic bit covers(input int x, input int y, input int cornerX, input int cornerY);
        return (x >= cornerX) && (y >= cornerY) &&
               (x - cornerX < spritePkg::spriteSize) && (y - cornerY < spritePkg::spriteSize);
    endfunction

    // each channel is filled out to 4 bits by repeating its top bits
    function automatic spritePkg::colourT widen(input spritePkg::pixelIndexT idx);
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
        red   = idx[7:5];
        green = idx[4:2];
        blue  = idx[1:0];
        return {red, red[2], green, green[2], blue, blue};
    endfunction

    task automatic modelPixel(input int x, input int y, output spritePkg::colourT expColour,
                              output bit drawn);
        int                    player;
        int                    dx;
        int                    dy;
        int                    heading;
        spritePkg::spriteWordT word;
        spritePkg::pixelIndexT idx;
        drawn     = 1'b0;
        expColour = backgroundColour;
        player    = -1;
        dx        = 0;
        dy        = 0;
        heading   = 0;
        // player 0 is tested first so it owns every overlapping pixel
        if (covers(x, y, int'(p0X), int'(p0Y))) begin
            player  = 0;
            dx      = x - int'(p0X);
            dy      = y - int'(p0Y);
            heading = int'(p0Heading);
        end else if (covers(x, y, int'(p1X), int'(p1Y))) begin
            player  = 1;
            dx      = x - int'(p1X);
            dy      = y - int'(p1Y);
            heading = int'(p1Heading);
        end
        if ((x >= activeWidth) || (y >= activeHeight)) begin
            expColour = '0;
        end else if (player >= 0) begin
            word = shadow[spritePkg::spriteAddrT'(player * 2048 + heading * 512 +
                                                  dy * 16 + dx / 2)];
            idx  = (dx % 2 == 1) ? word[15:8] : word[7:0];
            if (idx != '0) begin
                expColour = widen(idx);
                drawn     = 1'b1;
            end
        end
    endtask

    task automatic compare(input string where, input spritePkg::colourT expColour,
                           input logic expH, input logic expV, input logic expA);
        checkCount++;
        if ((colour !== expColour) || (hSync !== expH) || (vSync !== expV) ||
            (activeVideo !== expA)) begin
            errorCount++;
            if (errorCount <= maxReports) begin
                $display("[FAIL] %0d ns %s: got colour %h hs %b vs %b av %b, expected %h %b %b %b",
                         $time, where, colour, hSync, vSync, activeVideo,
                         expColour, expH, expV, expA);
            end
        end
    endtask

    // outputs settle after the rising edge, so they are read on the falling one
    always @(negedge Clk) begin
        spritePkg::colourT expColour;
        bit                drawn;
        logic              expH;
        logic              expV;
        logic              expA;
        if (edgeCount <= latency) begin
            modelX = 0;
            modelY = 0;
            compare("reset", '0, 1'b1, 1'b1, 1'b0);
        end else begin
            expA = (modelX < activeWidth) && (modelY < activeHeight);
            expH = !((modelX >= activeWidth + 8) && (modelX <= activeWidth + 23));
            expV = !((modelY == activeHeight + 2) || (modelY == activeHeight + 3));
            modelPixel(modelX, modelY, expColour, drawn);
            if (drawn) begin
                spriteCount++;
            end
            compare($sformatf("pixel (%0d,%0d)", modelX, modelY), expColour, expH, expV, expA);
            if (modelX == totalWidth - 1) begin
                modelX = 0;
                modelY = (modelY == totalHeight - 1) ? 0 : modelY + 1;
            end else begin
                modelX = modelX + 1;
            end
        end
    end

endmodule

//--- test/spriteEngineTb.sv
`timescale 1ns/100ps

module spriteEngineTb;

    localparam int activeWidth  = 160;
    localparam int activeHeight = 120;
    localparam int totalWidth   = 200;
    localparam int totalHeight  = 130;
    localparam int clockPeriod  = 4;
    localparam int resetCycles  = 5;
    localparam int loadCycles   = 4096;
    localparam int frameCycles  = totalWidth * totalHeight;
    localparam int frameCount   = 6;
    // one frame on top of the six covers the wait for the first vertical sync
    localparam int watchdogCycles = resetCycles + loadCycles + (frameCount + 1) * frameCycles;
    // parking spot for both bikes while the memory fills, beyond any raster column
    localparam spritePkg::coordT offScreen = 10'd1000;

    logic                  Clk;
    logic                  arstN;
    logic                  writeEnable;
    spritePkg::spriteAddrT writeAddr;
    spritePkg::spriteWordT writeData;
    spritePkg::coordT      p0X;
    spritePkg::coordT      p0Y;
    spritePkg::coordT      p1X;
    spritePkg::coordT      p1Y;
    spritePkg::headingT    p0Heading;
    spritePkg::headingT    p1Heading;
    spritePkg::colourT     backgroundColour;
    spritePkg::colourT     colour;
    logic                  hSync;
    logic                  vSync;
    logic                  activeVideo;
    int                    checkCount;
    int                    errorCount;
    int                    spriteCount;
    int                    seed;
    int                    lastChecks;
    int                    lastErrors;
    int                    lastSprites;
    int                    failedTests;

    clockGen #(.period(clockPeriod), .resetCycles(resetCycles)) clockGen_i (
        .Clk  (Clk),
        .arstN(arstN)
    );

    spriteEngine #(
        .activeWidth (activeWidth),
        .activeHeight(activeHeight),
        .totalWidth  (totalWidth),
        .totalHeight (totalHeight)
    ) spriteEngine_i (.*);

    spriteChecker #(
        .activeWidth (activeWidth),
        .activeHeight(activeHeight),
        .totalWidth  (totalWidth),
        .totalHeight (totalHeight)
    ) spriteChecker_i (.*);

    function automatic int randomBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // about one word in four gets a zero byte so transparency shows up
    task automatic loadMemory;
        spritePkg::spriteWordT word;
        for (int a = 0; a < loadCycles; a++) begin
            word = spritePkg::spriteWordT'($random(seed));
            if (randomBelow(4) == 0) begin
                if (randomBelow(2) == 0) begin
                    word[7:0] = '0;
                end else begin
                    word[15:8] = '0;
                end
            end
            writeEnable = 1'b1;
            writeAddr   = spritePkg::spriteAddrT'(a);
            writeData   = word;
            @(posedge Clk);
            #1;
        end
        writeEnable = 1'b0;
    endtask

    task automatic placePlayers(input int frame);
        // frames 3 and 6 hang both bikes over the right and bottom edges
        if (frame % 3 == 0) begin
            p0X = spritePkg::coordT'(activeWidth - 1 - randomBelow(spritePkg::spriteSize));
            p0Y = spritePkg::coordT'(activeHeight - 1 - randomBelow(spritePkg::spriteSize));
            p1X = spritePkg::coordT'(activeWidth - 1 - randomBelow(spritePkg::spriteSize));
            p1Y = spritePkg::coordT'(activeHeight - 1 - randomBelow(spritePkg::spriteSize));
        end else begin
            p0X = spritePkg::coordT'(randomBelow(activeWidth - spritePkg::spriteSize));
            p0Y = spritePkg::coordT'(randomBelow(activeHeight - spritePkg::spriteSize));
            p1X = spritePkg::coordT'(randomBelow(activeWidth));
            p1Y = spritePkg::coordT'(randomBelow(activeHeight));
        end
        if ((frame == 2) || (frame == 5)) begin
            p1X = spritePkg::coordT'(int'(p0X) + randomBelow(16));
            p1Y = spritePkg::coordT'(int'(p0Y) + randomBelow(16));
        end
        p0Heading        = spritePkg::headingT'(randomBelow(4));
        p1Heading        = spritePkg::headingT'(randomBelow(4));
        backgroundColour = spritePkg::colourT'(randomBelow(4096));
    endtask

    task automatic waitForVSync(input logic level);
        do begin
            @(negedge Clk);
        end while (vSync !== level);
    endtask

    // new settings go in during vertical sync so the next frame sees only one set
    task automatic showFrame(input int frame);
        waitForVSync(1'b0);
        @(posedge Clk);
        #1;
        placePlayers(frame);
        waitForVSync(1'b1);
        waitForVSync(1'b0);
    endtask

    task automatic reportTest(input string name);
        $display("test %s: %0d checks, %0d sprite pixels, %0d errors", name,
                 checkCount - lastChecks, spriteCount - lastSprites, errorCount - lastErrors);
        if (errorCount != lastErrors) begin
            failedTests++;
        end
        lastChecks  = checkCount;
        lastErrors  = errorCount;
        lastSprites = spriteCount;
    endtask

    initial begin
        seed             = 32'hf880_7968;
        writeEnable      = 1'b0;
        writeAddr        = '0;
        writeData        = '0;
        p0X              = offScreen;
        p0Y              = offScreen;
        p1X              = offScreen;
        p1Y              = offScreen;
        p0Heading        = spritePkg::up;
        p1Heading        = spritePkg::up;
        backgroundColour = 12'h248;
        lastChecks       = 0;
        lastErrors       = 0;
        lastSprites      = 0;
        failedTests      = 0;
        @(posedge arstN);
        @(posedge Clk);
        #1;
        loadMemory();
        reportTest("reset and memory load");
        for (int frame = 1; frame <= frameCount; frame++) begin
            showFrame(frame);
            reportTest($sformatf("frame %0d", frame));
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d sprite pixels, %0d errors",
                 frameCount + 1, failedTests, checkCount, spriteCount, errorCount);
        if ((errorCount == 0) && (spriteCount > 0)) begin
            $display("TEST PASSED");
        end else begin
            if (spriteCount == 0) begin
                $display("no sprite pixel was drawn in any frame");
            end
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("watchdog: the run timed out after %0d cycles", watchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule
